/* verilog/prf_defines.svh */
`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// Datapath and register file sizes.
`define PRF_XLEN        32
`define PRF_TAG_W       8
`define PRF_DEPTH       256
`define PRF_ARCH_REGS   32
`define PRF_WR_PORTS    5

// Issue to writeback cycles.
`define PRF_MUL_LATENCY 2
`define PRF_DIV_CYCLES  32

// ALU function codes.
`define PRF_ALU_FUNC_W  2
`define PRF_ALU_ADD     2'd0
`define PRF_ALU_SUB     2'd1
`define PRF_ALU_AND     2'd2
`define PRF_ALU_XOR     2'd3

`endif

/* verilog/prf_pkg.sv */
`default_nettype none

`include "prf_defines.svh"

package prf_pkg;

    typedef logic [`PRF_XLEN-1:0]       word_t;
    // Tag 0 is the hard zero register.
    typedef logic [`PRF_TAG_W-1:0]      preg_tag_t;
    typedef logic [`PRF_ALU_FUNC_W-1:0] alu_func_t;

    typedef struct packed {
        alu_func_t func;
        preg_tag_t src1;
        preg_tag_t src2;
        preg_tag_t dst;
    } issue_op_t;

    typedef struct packed {
        logic      valid;
        preg_tag_t tag;
        word_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

/* verilog/physical_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module physical_register_file (
    input  logic              clk,
    input  logic              reset,
    input  prf_pkg::preg_tag_t rd_src1,
    input  prf_pkg::preg_tag_t rd_src2,
    input  prf_pkg::preg_tag_t alloc_tag,
    input  prf_pkg::wb_t      alu_wb,
    input  prf_pkg::wb_t      ld_wb,
    input  prf_pkg::wb_t      mul_wb,
    input  prf_pkg::wb_t      div_wb,
    input  prf_pkg::wb_t      done_wb,
    input  prf_pkg::preg_tag_t alu_src1,
    input  prf_pkg::preg_tag_t alu_src2,
    input  prf_pkg::preg_tag_t mul_src1,
    input  prf_pkg::preg_tag_t mul_src2,
    input  prf_pkg::preg_tag_t div_src1,
    input  prf_pkg::preg_tag_t div_src2,
    input  prf_pkg::preg_tag_t br_src1,
    input  prf_pkg::preg_tag_t br_src2,
    output prf_pkg::word_t    rd_data1,
    output prf_pkg::word_t    rd_data2,
    output prf_pkg::word_t    alu_data1,
    output prf_pkg::word_t    alu_data2,
    output prf_pkg::word_t    mul_data1,
    output prf_pkg::word_t    mul_data2,
    output prf_pkg::word_t    div_data1,
    output prf_pkg::word_t    div_data2,
    output prf_pkg::word_t    br_data1,
    output prf_pkg::word_t    br_data2,
    output logic              rd_ready1,
    output logic              rd_ready2
);

    prf_pkg::word_t          regs [`PRF_DEPTH];
    logic [`PRF_DEPTH-1:0]   ready_q;
    prf_pkg::wb_t            wr_port [`PRF_WR_PORTS];

    // Ascending priority, the last port wins.
    assign wr_port[0] = alu_wb;
    assign wr_port[1] = ld_wb;
    assign wr_port[2] = mul_wb;
    assign wr_port[3] = div_wb;
    assign wr_port[4] = done_wb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs[i]    <= (i < `PRF_ARCH_REGS) ? prf_pkg::word_t'(i) : '0;
                ready_q[i] <= 1'b1;
            end
        end else begin
            for (int p = 0; p < `PRF_WR_PORTS; p++) begin
                if (wr_port[p].valid && wr_port[p].tag != '0) begin
                    regs[wr_port[p].tag]    <= wr_port[p].data;
                    ready_q[wr_port[p].tag] <= 1'b1;
                end
            end
            // Allocation clear overrides any same-cycle write.
            if (alloc_tag != '0) begin
                ready_q[alloc_tag] <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports, no bypass.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_data1  = regs[rd_src1];
    assign rd_data2  = regs[rd_src2];
    assign rd_ready1 = ready_q[rd_src1];
    assign rd_ready2 = ready_q[rd_src2];

    assign alu_data1 = regs[alu_src1];
    assign alu_data2 = regs[alu_src2];
    assign mul_data1 = regs[mul_src1];
    assign mul_data2 = regs[mul_src2];
    assign div_data1 = regs[div_src1];
    assign div_data2 = regs[div_src2];
    assign br_data1  = regs[br_src1];
    assign br_data2  = regs[br_src2];

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module int_alu (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  prf_pkg::issue_op_t op,
    output prf_pkg::preg_tag_t src1,
    output prf_pkg::preg_tag_t src2,
    input  prf_pkg::word_t     data1,
    input  prf_pkg::word_t     data2,
    output prf_pkg::wb_t       wb
);

    prf_pkg::word_t result;

    assign src1 = op.src1;
    assign src2 = op.src2;

    always_comb begin
        result = '0;
        case (op.func)
            `PRF_ALU_ADD: result = data1 + data2;
            `PRF_ALU_SUB: result = data1 - data2;
            `PRF_ALU_AND: result = data1 & data2;
            `PRF_ALU_XOR: result = data1 ^ data2;
        endcase
    end

    // One cycle to writeback.
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue;
        end
        if (issue) begin
            wb.tag  <= op.dst;
            wb.data <= result;
        end
    end

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  prf_pkg::issue_op_t op,
    output prf_pkg::preg_tag_t src1,
    output prf_pkg::preg_tag_t src2,
    input  prf_pkg::word_t     data1,
    input  prf_pkg::word_t     data2,
    output prf_pkg::wb_t       wb
);

    logic               s1_valid;
    prf_pkg::word_t     s1_a;
    prf_pkg::word_t     s1_b;
    prf_pkg::preg_tag_t s1_dst;

    assign src1 = op.src1;
    assign src2 = op.src2;

    // Valid bits move with their payload.
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            wb.valid <= s1_valid;
        end
        // Stage one, operand capture.
        s1_a   <= data1;
        s1_b   <= data2;
        s1_dst <= op.dst;
        // Stage two, low word of the product.
        wb.tag  <= s1_dst;
        wb.data <= s1_a * s1_b;
    end

endmodule

`default_nettype wire

/* verilog/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module div_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  prf_pkg::issue_op_t op,
    output prf_pkg::preg_tag_t src1,
    output prf_pkg::preg_tag_t src2,
    input  prf_pkg::word_t     data1,
    input  prf_pkg::word_t     data2,
    output prf_pkg::wb_t       wb,
    output logic               busy
);

    prf_pkg::div_state_t state_q;
    logic [4:0]          count_q;
    prf_pkg::word_t      rem_q;
    prf_pkg::word_t      quo_q;
    prf_pkg::word_t      divisor_q;
    prf_pkg::preg_tag_t  dst_q;
    logic [`PRF_XLEN:0]  rem_shift;
    prf_pkg::word_t      step_rem;
    prf_pkg::word_t      step_quo;

    assign src1 = op.src1;
    assign src2 = op.src2;

    // One restoring step. A zero divisor always subtracts, so the quotient is all ones.
    always_comb begin
        rem_shift = {rem_q, quo_q[`PRF_XLEN-1]};
        if (rem_shift >= {1'b0, divisor_q}) begin
            step_rem = prf_pkg::word_t'(rem_shift - {1'b0, divisor_q});
            step_quo = {quo_q[`PRF_XLEN-2:0], 1'b1};
        end else begin
            step_rem = rem_shift[`PRF_XLEN-1:0];
            step_quo = {quo_q[`PRF_XLEN-2:0], 1'b0};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer: 31 steps in RUN, the last one in DONE.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= prf_pkg::DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                prf_pkg::DIV_IDLE: begin
                    if (issue) begin
                        state_q <= prf_pkg::DIV_RUN;
                        count_q <= '0;
                    end
                end
                prf_pkg::DIV_RUN: begin
                    count_q <= count_q + 5'd1;
                    if (count_q == 5'(`PRF_DIV_CYCLES - 2)) begin
                        state_q <= prf_pkg::DIV_DONE;
                    end
                end
                default: state_q <= prf_pkg::DIV_IDLE;
            endcase
        end
        if (state_q == prf_pkg::DIV_IDLE && issue) begin
            rem_q     <= '0;
            quo_q     <= data1;
            divisor_q <= data2;
            dst_q     <= op.dst;
        end else if (state_q == prf_pkg::DIV_RUN) begin
            rem_q <= step_rem;
            quo_q <= step_quo;
        end
    end

    assign busy = (state_q != prf_pkg::DIV_IDLE);

    always_comb begin
        wb.valid = (state_q == prf_pkg::DIV_DONE);
        wb.tag   = dst_q;
        wb.data  = step_quo;
    end

endmodule

`default_nettype wire

/* verilog/exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic               clk,
    input  logic               reset,
    input  prf_pkg::preg_tag_t disp_src1,
    input  prf_pkg::preg_tag_t disp_src2,
    input  prf_pkg::preg_tag_t alloc_tag,
    output prf_pkg::word_t     disp_data1,
    output prf_pkg::word_t     disp_data2,
    output logic               disp_ready1,
    output logic               disp_ready2,
    input  logic               alu_issue,
    input  prf_pkg::issue_op_t alu_op,
    input  logic               mul_issue,
    input  prf_pkg::issue_op_t mul_op,
    input  logic               div_issue,
    input  prf_pkg::issue_op_t div_op,
    input  prf_pkg::wb_t       ld_wb,
    input  prf_pkg::wb_t       done_wb,
    input  prf_pkg::preg_tag_t br_src1,
    input  prf_pkg::preg_tag_t br_src2,
    output prf_pkg::word_t     br_data1,
    output prf_pkg::word_t     br_data2,
    output logic               div_busy
);

    prf_pkg::preg_tag_t alu_src1, alu_src2;
    prf_pkg::preg_tag_t mul_src1, mul_src2;
    prf_pkg::preg_tag_t div_src1, div_src2;
    prf_pkg::word_t     alu_data1, alu_data2;
    prf_pkg::word_t     mul_data1, mul_data2;
    prf_pkg::word_t     div_data1, div_data2;
    prf_pkg::wb_t       alu_wb, mul_wb, div_wb;

    physical_register_file prf_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_src1   (disp_src1),
        .rd_src2   (disp_src2),
        .alloc_tag (alloc_tag),
        .alu_wb    (alu_wb),
        .ld_wb     (ld_wb),
        .mul_wb    (mul_wb),
        .div_wb    (div_wb),
        .done_wb   (done_wb),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .mul_src1  (mul_src1),
        .mul_src2  (mul_src2),
        .div_src1  (div_src1),
        .div_src2  (div_src2),
        .br_src1   (br_src1),
        .br_src2   (br_src2),
        .rd_data1  (disp_data1),
        .rd_data2  (disp_data2),
        .alu_data1 (alu_data1),
        .alu_data2 (alu_data2),
        .mul_data1 (mul_data1),
        .mul_data2 (mul_data2),
        .div_data1 (div_data1),
        .div_data2 (div_data2),
        .br_data1  (br_data1),
        .br_data2  (br_data2),
        .rd_ready1 (disp_ready1),
        .rd_ready2 (disp_ready2)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execution units.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    int_alu alu_inst (
        .clk   (clk),
        .reset (reset),
        .issue (alu_issue),
        .op    (alu_op),
        .src1  (alu_src1),
        .src2  (alu_src2),
        .data1 (alu_data1),
        .data2 (alu_data2),
        .wb    (alu_wb)
    );

    mul_unit mul_inst (
        .clk   (clk),
        .reset (reset),
        .issue (mul_issue),
        .op    (mul_op),
        .src1  (mul_src1),
        .src2  (mul_src2),
        .data1 (mul_data1),
        .data2 (mul_data2),
        .wb    (mul_wb)
    );

    div_unit div_inst (
        .clk   (clk),
        .reset (reset),
        .issue (div_issue),
        .op    (div_op),
        .src1  (div_src1),
        .src2  (div_src2),
        .data1 (div_data1),
        .data2 (div_data2),
        .wb    (div_wb),
        .busy  (div_busy)
    );

endmodule

`default_nettype wire

/* verif/exec_cluster_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module exec_cluster_properties (
    input  logic           clk,
    input  logic           reset,
    input  prf_pkg::word_t zero_entry,
    input  logic [4:0]     wb_valids,
    input  logic           div_issue,
    input  logic           div_busy,
    input  logic           div_wb_valid
);

    // Tag 0 is the hard zero register.
    zero_reg_holds: assert property (@(posedge clk) disable iff (reset) zero_entry == '0)
        else $error("Physical register 0 holds a nonzero value.");

    issue_while_busy: assert property (@(posedge clk) disable iff (reset)
        div_busy |-> !div_issue)
        else $error("Divider issued while busy.");

    // Accepted issue to writeback, in both directions.
    div_latency: assert property (@(posedge clk) disable iff (reset)
        (div_issue && !div_busy) |-> ##(`PRF_DIV_CYCLES) div_wb_valid)
        else $error("Divider writeback missing after an accepted issue.");

    div_wb_origin: assert property (@(posedge clk) disable iff (reset)
        div_wb_valid |-> $past(div_issue && !div_busy, `PRF_DIV_CYCLES))
        else $error("Divider writeback without an issue at the expected distance.");

    quiet_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> wb_valids == '0)
        else $error("Writeback valid seen during reset.");

endmodule

bind physical_register_file exec_cluster_properties prf_props_inst (
    .clk          (clk),
    .reset        (reset),
    .zero_entry   (regs[0]),
    .wb_valids    ({alu_wb.valid, ld_wb.valid, mul_wb.valid, div_wb.valid, done_wb.valid}),
    .div_issue    (1'b0),
    .div_busy     (1'b0),
    .div_wb_valid (1'b0)
);

bind div_unit exec_cluster_properties div_props_inst (
    .clk          (clk),
    .reset        (reset),
    .zero_entry   ('0),
    .wb_valids    ({4'b0000, wb.valid}),
    .div_issue    (issue),
    .div_busy     (busy),
    .div_wb_valid (wb.valid)
);

`default_nettype wire

/* verif/exec_cluster_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module exec_cluster_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic [2:0]         test_id,
    input  prf_pkg::preg_tag_t disp_src1,
    input  prf_pkg::preg_tag_t disp_src2,
    input  prf_pkg::preg_tag_t alloc_tag,
    input  prf_pkg::word_t     disp_data1,
    input  prf_pkg::word_t     disp_data2,
    input  logic               disp_ready1,
    input  logic               disp_ready2,
    input  logic               alu_issue,
    input  prf_pkg::issue_op_t alu_op,
    input  logic               mul_issue,
    input  prf_pkg::issue_op_t mul_op,
    input  logic               div_issue,
    input  prf_pkg::issue_op_t div_op,
    input  prf_pkg::wb_t       ld_wb,
    input  prf_pkg::wb_t       done_wb,
    input  prf_pkg::preg_tag_t br_src1,
    input  prf_pkg::preg_tag_t br_src2,
    input  prf_pkg::word_t     br_data1,
    input  prf_pkg::word_t     br_data2,
    input  logic               div_busy,
    output int                 error_count,
    output int                 check_count
);

    prf_pkg::word_t        model_data [`PRF_DEPTH];
    logic [`PRF_DEPTH-1:0] model_ready;
    prf_pkg::wb_t          alu_pend;
    prf_pkg::wb_t          mul_pend1;
    prf_pkg::wb_t          mul_pend2;
    prf_pkg::wb_t          div_pend;
    int                    div_left;
    int                    errors = 0;
    int                    checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_sweep";
            3'd2:    return "random_ops";
            3'd3:    return "mul_burst";
            3'd4:    return "alloc_ready";
            3'd5:    return "write_priority";
            3'd6:    return "final_sweep";
            default: return "reset";
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unit result models.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic prf_pkg::word_t alu_model(input prf_pkg::alu_func_t func,
                                                 input prf_pkg::word_t a,
                                                 input prf_pkg::word_t b);
        case (func)
            `PRF_ALU_ADD: return a + b;
            `PRF_ALU_SUB: return a + ~b + 32'd1;
            `PRF_ALU_AND: return a & b;
            default:      return a ^ b;
        endcase
    endfunction

    function automatic prf_pkg::word_t mul_model(input prf_pkg::word_t a,
                                                 input prf_pkg::word_t b);
        logic [63:0] product;
        product = {32'b0, a} * {32'b0, b};
        return product[31:0];
    endfunction

    function automatic prf_pkg::word_t div_model(input prf_pkg::word_t a,
                                                 input prf_pkg::word_t b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    task automatic apply_write(input prf_pkg::wb_t w);
        if (w.valid && w.tag != '0) begin
            model_data[w.tag]  = w.data;
            model_ready[w.tag] = 1'b1;
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name(test_id), what, expected, actual);
        end
    endtask

    always @(posedge clk) begin : model_step
        prf_pkg::wb_t new_alu;
        prf_pkg::wb_t new_mul;
        logic         div_fire;
        if (reset) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                model_data[i] = (i < `PRF_ARCH_REGS) ? prf_pkg::word_t'(i) : '0;
            end
            model_ready = '1;
            alu_pend    = '0;
            mul_pend1   = '0;
            mul_pend2   = '0;
            div_pend    = '0;
            div_left    = 0;
        end else begin
            compare_word($sformatf("disp_data1[%0d]", disp_src1),
                         model_data[disp_src1], disp_data1);
            compare_word($sformatf("disp_data2[%0d]", disp_src2),
                         model_data[disp_src2], disp_data2);
            compare_word($sformatf("disp_ready1[%0d]", disp_src1),
                         {31'b0, model_ready[disp_src1]}, {31'b0, disp_ready1});
            compare_word($sformatf("disp_ready2[%0d]", disp_src2),
                         {31'b0, model_ready[disp_src2]}, {31'b0, disp_ready2});
            compare_word($sformatf("br_data1[%0d]", br_src1),
                         model_data[br_src1], br_data1);
            compare_word($sformatf("br_data2[%0d]", br_src2),
                         model_data[br_src2], br_data2);
            // Busy from the cycle after issue through the writeback cycle.
            compare_word("div_busy", {31'b0, div_left > 0}, {31'b0, div_busy});

            // Operands come from the state before this edge.
            new_alu = {alu_issue, alu_op.dst,
                       alu_model(alu_op.func, model_data[alu_op.src1], model_data[alu_op.src2])};
            new_mul = {mul_issue, mul_op.dst,
                       mul_model(model_data[mul_op.src1], model_data[mul_op.src2])};
            div_fire = 1'b0;
            if (div_left > 0) begin
                div_left--;
                div_fire = (div_left == 0);
            end else if (div_issue) begin
                div_pend = {1'b1, div_op.dst,
                            div_model(model_data[div_op.src1], model_data[div_op.src2])};
                div_left = `PRF_DIV_CYCLES;
            end

            // Lowest priority first and the allocation clear last.
            apply_write(alu_pend);
            apply_write(ld_wb);
            apply_write(mul_pend2);
            if (div_fire) begin
                apply_write(div_pend);
            end
            apply_write(done_wb);
            if (alloc_tag != '0) begin
                model_ready[alloc_tag] = 1'b0;
            end

            alu_pend  = new_alu;
            mul_pend2 = mul_pend1;
            mul_pend1 = new_mul;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prf_defines.svh"

module tb_exec_cluster;

    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 2000;
    localparam int BURST_CYCLES  = 64;
    localparam int TEST_CYCLES   = RESET_CYCLES + 2 * `PRF_DEPTH + RANDOM_CYCLES
                                   + BURST_CYCLES + 2 * `PRF_DIV_CYCLES + 100;
    localparam int MARGIN_CYCLES = 200;

    logic               clk;
    logic               reset;
    logic [2:0]         test_id;
    prf_pkg::preg_tag_t disp_src1;
    prf_pkg::preg_tag_t disp_src2;
    prf_pkg::preg_tag_t alloc_tag;
    prf_pkg::word_t     disp_data1;
    prf_pkg::word_t     disp_data2;
    logic               disp_ready1;
    logic               disp_ready2;
    logic               alu_issue;
    logic               mul_issue;
    logic               div_issue;
    prf_pkg::issue_op_t alu_op;
    prf_pkg::issue_op_t mul_op;
    prf_pkg::issue_op_t div_op;
    prf_pkg::wb_t       ld_wb;
    prf_pkg::wb_t       done_wb;
    prf_pkg::preg_tag_t br_src1;
    prf_pkg::preg_tag_t br_src2;
    prf_pkg::word_t     br_data1;
    prf_pkg::word_t     br_data2;
    logic               div_busy;
    int                 error_count;
    int                 check_count;
    logic [31:0]        rng = 32'hc1b38fe5;

    exec_cluster exec_cluster_inst (
        .clk         (clk),
        .reset       (reset),
        .disp_src1   (disp_src1),
        .disp_src2   (disp_src2),
        .alloc_tag   (alloc_tag),
        .disp_data1  (disp_data1),
        .disp_data2  (disp_data2),
        .disp_ready1 (disp_ready1),
        .disp_ready2 (disp_ready2),
        .alu_issue   (alu_issue),
        .alu_op      (alu_op),
        .mul_issue   (mul_issue),
        .mul_op      (mul_op),
        .div_issue   (div_issue),
        .div_op      (div_op),
        .ld_wb       (ld_wb),
        .done_wb     (done_wb),
        .br_src1     (br_src1),
        .br_src2     (br_src2),
        .br_data1    (br_data1),
        .br_data2    (br_data2),
        .div_busy    (div_busy)
    );

    exec_cluster_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .test_id     (test_id),
        .disp_src1   (disp_src1),
        .disp_src2   (disp_src2),
        .alloc_tag   (alloc_tag),
        .disp_data1  (disp_data1),
        .disp_data2  (disp_data2),
        .disp_ready1 (disp_ready1),
        .disp_ready2 (disp_ready2),
        .alu_issue   (alu_issue),
        .alu_op      (alu_op),
        .mul_issue   (mul_issue),
        .mul_op      (mul_op),
        .div_issue   (div_issue),
        .div_op      (div_op),
        .ld_wb       (ld_wb),
        .done_wb     (done_wb),
        .br_src1     (br_src1),
        .br_src2     (br_src2),
        .br_data1    (br_data1),
        .br_data2    (br_data2),
        .div_busy    (div_busy),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source and stimulus helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Small tag pool so reads and writes collide often.
    function automatic prf_pkg::preg_tag_t pool_tag();
        return prf_pkg::preg_tag_t'(rand_word() & 32'h3f);
    endfunction

    function automatic prf_pkg::issue_op_t random_op();
        return {prf_pkg::alu_func_t'(rand_word()), pool_tag(), pool_tag(), pool_tag()};
    endfunction

    task automatic idle_inputs();
        alu_issue <= 1'b0;
        mul_issue <= 1'b0;
        div_issue <= 1'b0;
        alu_op    <= '0;
        mul_op    <= '0;
        div_op    <= '0;
        alloc_tag <= '0;
        ld_wb     <= '0;
        done_wb   <= '0;
    endtask

    task automatic sweep_all_tags();
        for (int t = 0; t < `PRF_DEPTH; t++) begin
            @(posedge clk);
            idle_inputs();
            disp_src1 <= prf_pkg::preg_tag_t'(t);
            disp_src2 <= prf_pkg::preg_tag_t'(`PRF_DEPTH - 1 - t);
            br_src1   <= prf_pkg::preg_tag_t'(t);
            br_src2   <= prf_pkg::preg_tag_t'(t * 7);
        end
    endtask

    task automatic drive_random_cycle();
        logic [31:0] r;
        r = rand_word();
        idle_inputs();
        alu_issue <= r[0];
        alu_op    <= random_op();
        mul_issue <= r[1];
        mul_op    <= random_op();
        // Issue only when the divider is idle and no issue is pending.
        if (!div_busy && !div_issue && r[4:2] == 3'd0) begin
            div_issue <= 1'b1;
            div_op    <= random_op();
        end
        if (r[7:5] == 3'd0) begin
            alloc_tag <= pool_tag();
        end
        ld_wb     <= {r[8], pool_tag(), rand_word()};
        done_wb   <= {r[9] & r[10], pool_tag(), rand_word()};
        disp_src1 <= pool_tag();
        disp_src2 <= pool_tag();
        br_src1   <= r[11] ? prf_pkg::preg_tag_t'(rand_word()) : pool_tag();
        br_src2   <= pool_tag();
    endtask

    task automatic hold_reads(input prf_pkg::preg_tag_t tag, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            idle_inputs();
            disp_src1 <= tag;
            disp_src2 <= tag;
            br_src1   <= tag;
            br_src2   <= tag;
        end
    endtask

    task automatic check_alloc_ready();
        @(posedge clk);
        idle_inputs();
        alloc_tag <= 8'd40;
        hold_reads(8'd40, 3);
        @(posedge clk);
        idle_inputs();
        ld_wb <= {1'b1, 8'd40, 32'h1234_5678};
        hold_reads(8'd40, 3);
        // Clear and write to one tag in the same cycle.
        @(posedge clk);
        idle_inputs();
        alloc_tag <= 8'd41;
        done_wb   <= {1'b1, 8'd41, 32'hcafe_f00d};
        hold_reads(8'd41, 3);
        @(posedge clk);
        idle_inputs();
        ld_wb <= {1'b1, 8'd41, 32'h0bad_cafe};
        hold_reads(8'd41, 3);
    endtask

    // Multiplier, ALU, load and done writes all land on one edge.
    task automatic collide_writes(input prf_pkg::preg_tag_t tag, input logic use_mul,
                                  input logic use_done);
        @(posedge clk);
        idle_inputs();
        mul_issue <= use_mul;
        mul_op    <= {`PRF_ALU_ADD, 8'd3, 8'd5, tag};
        @(posedge clk);
        idle_inputs();
        alu_issue <= 1'b1;
        alu_op    <= {`PRF_ALU_XOR, 8'd7, 8'd9, tag};
        @(posedge clk);
        idle_inputs();
        ld_wb   <= {1'b1, tag, rand_word()};
        done_wb <= {use_done, tag, rand_word()};
        hold_reads(tag, 3);
    endtask

    initial begin : watchdog
        repeat (TEST_CYCLES + MARGIN_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        test_id   = 3'd0;
        disp_src1 = '0;
        disp_src2 = '0;
        br_src1   = '0;
        br_src2   = '0;
        alu_issue = 1'b0;
        mul_issue = 1'b0;
        div_issue = 1'b0;
        alu_op    = '0;
        mul_op    = '0;
        div_op    = '0;
        alloc_tag = '0;
        ld_wb     = '0;
        done_wb   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset   <= 1'b0;
        test_id <= 3'd1;
        sweep_all_tags();

        test_id <= 3'd2;
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            drive_random_cycle();
        end

        test_id <= 3'd3;
        repeat (BURST_CYCLES) begin
            @(posedge clk);
            idle_inputs();
            mul_issue <= 1'b1;
            mul_op    <= random_op();
            disp_src1 <= pool_tag();
            disp_src2 <= pool_tag();
            br_src1   <= pool_tag();
        end

        test_id <= 3'd4;
        check_alloc_ready();

        test_id <= 3'd5;
        collide_writes(8'd50, 1'b1, 1'b1);
        collide_writes(8'd51, 1'b1, 1'b0);
        collide_writes(8'd52, 1'b0, 1'b0);
        collide_writes(8'd0, 1'b1, 1'b1);

        // Let a divide in flight finish before the last sweep.
        do begin
            @(posedge clk);
            idle_inputs();
        end while (div_busy || div_issue);
        test_id <= 3'd6;
        sweep_all_tags();
        repeat (4) @(posedge clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_cluster.f */
+incdir+verilog
verilog/prf_pkg.sv
verilog/physical_register_file.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/exec_cluster.sv
verif/exec_cluster_properties.sv
verif/exec_cluster_checker.sv
verif/tb_exec_cluster.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f exec_cluster.f \
    --top-module tb_exec_cluster \
    -Mdir obj_dir -o sim_exec_cluster

./obj_dir/sim_exec_cluster | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
